/* design/cpu_pkg.sv */
package cpu_pkg;

    typedef enum logic [5:0] {
        OP_INVALID,
        OP_ADD, OP_ADDU, OP_SUB, OP_SUBU,
        OP_SLT, OP_SLTU,
        OP_AND, OP_OR, OP_XOR, OP_NOR,
        OP_SLL, OP_SRL, OP_SRA,
        OP_SLLV, OP_SRLV, OP_SRAV,
        OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU,
        OP_ANDI, OP_ORI, OP_XORI,
        OP_LUI,
        OP_MOVN, OP_MOVZ,
        OP_MFHI, OP_MFLO, OP_MTHI, OP_MTLO,
        OP_TEQ, OP_TNE, OP_TEQI,
        OP_SYSCALL, OP_BREAK
    } operation_t;

    // one instruction word, read as R or I format
    typedef union packed {
        struct packed {
            logic [5:0] op;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [4:0] sa;
            logic [5:0] func;
        } r_fmt;
        struct packed {
            logic [5:0]  op;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm;
        } i_fmt;
    } inst_u;

    typedef struct packed {
        operation_t  operation;
        logic [5:0]  src1;
        logic [5:0]  src2;
        logic [5:0]  dest;
        logic        rf_we;
        logic        use_old_dest;
        logic        src1_is_sa;
        logic        src2_is_simm;
        logic        src2_is_zimm;
        logic [4:0]  sa;
        logic [15:0] imm;
    } decoded_inst_t;

    typedef struct packed {
        logic        ex;
        logic [4:0]  exccode;
        logic [31:0] epc;
    } exception_t;

    localparam logic [4:0] EXCCODE_SYS = 5'd8;
    localparam logic [4:0] EXCCODE_BP  = 5'd9;
    localparam logic [4:0] EXCCODE_RI  = 5'd10;
    localparam logic [4:0] EXCCODE_OV  = 5'd12;
    localparam logic [4:0] EXCCODE_TR  = 5'd13;

    // 6-bit register indices, 32 and up are not general registers
    localparam logic [5:0] REG_HI     = 6'd32;
    localparam logic [5:0] REG_LO     = 6'd33;
    localparam logic [5:0] ADR_STATUS = 6'd34;
    localparam logic [5:0] ADR_EPC    = 6'd35;

    localparam logic [5:0] OPC_SPECIAL = 6'b000000;
    localparam logic [5:0] OPC_REGIMM  = 6'b000001;
    localparam logic [4:0] RT_TEQI     = 5'b01100;

    // issue port states
    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_BUSY = 2'd1;
    localparam logic [1:0] ST_ACK  = 2'd2;

endpackage

/* design/exec_bus_if.sv */
`timescale 1ns/1ps

interface exec_bus_if;
    import cpu_pkg::*;

    logic          valid;
    decoded_inst_t inst;
    exception_t    exc;
    logic [31:0]   pc;
    logic [5:0]    dest;
    logic          rf_we;
    logic [31:0]   result;
    logic          write_hilo;

    modport producer (
        output valid, inst, exc, pc, dest, rf_we, result, write_hilo
    );
    modport consumer (
        input valid, inst, exc, pc, dest, rf_we, result, write_hilo
    );

endinterface

/* design/wb_issue_port.sv */
`timescale 1ns/1ps

module wb_issue_port (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           wb_cyc,
    input  logic           wb_stb,
    input  logic           wb_we,
    input  logic [31:0]    wb_dat_i,
    output logic           wb_ack,
    output logic           issue_valid,
    output cpu_pkg::inst_u inst,
    output logic [31:0]    pc,
    input  logic           commit_done
);
    import cpu_pkg::*;

    logic [1:0] state;
    logic       req;

    assign req    = wb_cyc && wb_stb;
    assign wb_ack = state == ST_ACK;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= ST_IDLE;
            issue_valid <= 1'b0;
            pc          <= 32'd0;
        end else begin
            issue_valid <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (req) begin
                        // reads ack next cycle, writes wait for commit
                        state       <= wb_we ? ST_BUSY : ST_ACK;
                        issue_valid <= wb_we;
                    end
                end
                ST_BUSY: begin
                    if (commit_done) begin
                        state <= ST_ACK;
                        pc    <= pc + 32'd4;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_IDLE && req && wb_we) begin
            inst <= wb_dat_i;
        end
    end

endmodule

/* design/inst_decode.sv */
`timescale 1ns/1ps

module inst_decode (
    input  cpu_pkg::inst_u      inst,
    output cpu_pkg::operation_t operation
);
    import cpu_pkg::*;

    always_comb begin
        operation = OP_INVALID;
        case (inst.r_fmt.op)
            OPC_SPECIAL: begin
                case (inst.r_fmt.func)
                    6'b000000: operation = OP_SLL;
                    6'b000010: operation = OP_SRL;
                    6'b000011: operation = OP_SRA;
                    6'b000100: operation = OP_SLLV;
                    6'b000110: operation = OP_SRLV;
                    6'b000111: operation = OP_SRAV;
                    6'b001010: operation = OP_MOVZ;
                    6'b001011: operation = OP_MOVN;
                    6'b001100: operation = OP_SYSCALL;
                    6'b001101: operation = OP_BREAK;
                    6'b010000: operation = OP_MFHI;
                    6'b010001: operation = OP_MTHI;
                    6'b010010: operation = OP_MFLO;
                    6'b010011: operation = OP_MTLO;
                    6'b100000: operation = OP_ADD;
                    6'b100001: operation = OP_ADDU;
                    6'b100010: operation = OP_SUB;
                    6'b100011: operation = OP_SUBU;
                    6'b100100: operation = OP_AND;
                    6'b100101: operation = OP_OR;
                    6'b100110: operation = OP_XOR;
                    6'b100111: operation = OP_NOR;
                    6'b101010: operation = OP_SLT;
                    6'b101011: operation = OP_SLTU;
                    6'b110100: operation = OP_TEQ;
                    6'b110110: operation = OP_TNE;
                    default:   operation = OP_INVALID;
                endcase
            end
            // only TEQI is kept from the regimm group
            OPC_REGIMM: begin
                if (inst.i_fmt.rt == RT_TEQI) begin
                    operation = OP_TEQI;
                end
            end
            6'b001000: operation = OP_ADDI;
            6'b001001: operation = OP_ADDIU;
            6'b001010: operation = OP_SLTI;
            6'b001011: operation = OP_SLTIU;
            6'b001100: operation = OP_ANDI;
            6'b001101: operation = OP_ORI;
            6'b001110: operation = OP_XORI;
            6'b001111: operation = OP_LUI;
            default:   operation = OP_INVALID;
        endcase
    end

endmodule

/* design/control_signal.sv */
`timescale 1ns/1ps

module control_signal (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                issue_valid,
    input  logic [31:0]         pc,
    input  cpu_pkg::inst_u      inst,
    input  cpu_pkg::operation_t operation,
    exec_bus_if.producer        bus
);
    import cpu_pkg::*;

    decoded_inst_t inst_d;
    exception_t    exc_d;
    logic [5:0]    rs, rt, rd;

    assign rs = {1'b0, inst.r_fmt.rs};
    assign rt = {1'b0, inst.r_fmt.rt};
    assign rd = {1'b0, inst.r_fmt.rd};

    always_comb begin
        exc_d     = '0;
        exc_d.epc = pc;
        case (operation)
            OP_INVALID: begin
                exc_d.ex      = 1'b1;
                exc_d.exccode = EXCCODE_RI;
            end
            OP_SYSCALL: begin
                exc_d.ex      = 1'b1;
                exc_d.exccode = EXCCODE_SYS;
            end
            OP_BREAK: begin
                exc_d.ex      = 1'b1;
                exc_d.exccode = EXCCODE_BP;
            end
            default: exc_d.ex = 1'b0;
        endcase
    end

    always_comb begin
        inst_d              = '0;
        inst_d.sa           = inst.r_fmt.sa;
        inst_d.imm          = inst.i_fmt.imm;
        inst_d.use_old_dest = operation == OP_MOVN || operation == OP_MOVZ;

        // immediate and variable forms share the base alu op
        case (operation)
            OP_ADDI:  inst_d.operation = OP_ADD;
            OP_ADDIU: inst_d.operation = OP_ADDU;
            OP_SLTI:  inst_d.operation = OP_SLT;
            OP_SLTIU: inst_d.operation = OP_SLTU;
            OP_ANDI:  inst_d.operation = OP_AND;
            OP_ORI:   inst_d.operation = OP_OR;
            OP_XORI:  inst_d.operation = OP_XOR;
            OP_SLLV:  inst_d.operation = OP_SLL;
            OP_SRLV:  inst_d.operation = OP_SRL;
            OP_SRAV:  inst_d.operation = OP_SRA;
            OP_TEQI:  inst_d.operation = OP_TEQ;
            default:  inst_d.operation = operation;
        endcase

        case (operation)
            OP_ADD, OP_ADDU, OP_SUB, OP_SUBU, OP_SLT, OP_SLTU,
            OP_AND, OP_OR, OP_XOR, OP_NOR, OP_SLLV, OP_SRLV, OP_SRAV,
            OP_MOVN, OP_MOVZ, OP_TEQ, OP_TNE: begin
                inst_d.src1 = rs;
                inst_d.src2 = rt;
            end
            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI,
            OP_MTHI, OP_MTLO, OP_TEQI: inst_d.src1 = rs;
            OP_SLL, OP_SRL, OP_SRA: begin
                inst_d.src2       = rt;
                inst_d.src1_is_sa = 1'b1;
            end
            OP_MFHI: inst_d.src1 = REG_HI;
            OP_MFLO: inst_d.src1 = REG_LO;
            default: inst_d.src1 = 6'd0;
        endcase

        inst_d.src2_is_simm = operation inside {OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_TEQI};
        inst_d.src2_is_zimm = operation inside {OP_ANDI, OP_ORI, OP_XORI};

        case (operation)
            OP_ADD, OP_ADDU, OP_SUB, OP_SUBU, OP_SLT, OP_SLTU,
            OP_AND, OP_OR, OP_XOR, OP_NOR, OP_SLL, OP_SRL, OP_SRA,
            OP_SLLV, OP_SRLV, OP_SRAV, OP_MFHI, OP_MFLO, OP_MOVN, OP_MOVZ: begin
                inst_d.rf_we = rd != 6'd0;
                inst_d.dest  = rd;
            end
            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU,
            OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                inst_d.rf_we = rt != 6'd0;
                inst_d.dest  = rt;
            end
            OP_MTHI: begin
                inst_d.rf_we = 1'b1;
                inst_d.dest  = REG_HI;
            end
            OP_MTLO: begin
                inst_d.rf_we = 1'b1;
                inst_d.dest  = REG_LO;
            end
            default: inst_d.rf_we = 1'b0;
        endcase
    end

    assign bus.result = 32'd0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bus.valid <= 1'b0;
        end else begin
            bus.valid <= issue_valid;
        end
    end

    always_ff @(posedge clk) begin
        bus.inst       <= inst_d;
        bus.exc        <= exc_d;
        bus.pc         <= pc;
        bus.dest       <= inst_d.dest;
        bus.rf_we      <= inst_d.rf_we;
        bus.write_hilo <= inst_d.dest[5];
    end

endmodule

/* design/exec_alu.sv */
`timescale 1ns/1ps

module exec_alu (
    input  logic         clk,
    input  logic         rst_n,
    exec_bus_if.consumer in_bus,
    exec_bus_if.producer out_bus,
    output logic [5:0]   rd_idx1,
    output logic [5:0]   rd_idx2,
    input  logic [31:0]  rd_val1,
    input  logic [31:0]  rd_val2
);
    import cpu_pkg::*;

    decoded_inst_t d;
    exception_t    exc;
    logic [31:0]   op1, op2, sum, diff, result;
    logic          move_cond, trap, ovf;

    assign d = in_bus.inst;

    // movn/movz read the old rd on port 1 when the condition fails
    assign move_cond = (d.operation == OP_MOVN) ? (rd_val2 != 32'd0) : (rd_val2 == 32'd0);
    assign rd_idx2   = d.src2;
    assign rd_idx1   = (d.use_old_dest && !move_cond) ? in_bus.dest : d.src1;

    assign op1  = d.src1_is_sa ? {27'd0, d.sa} : rd_val1;
    assign op2  = d.src2_is_simm ? {{16{d.imm[15]}}, d.imm} :
                  d.src2_is_zimm ? {16'd0, d.imm} : rd_val2;
    assign sum  = op1 + op2;
    assign diff = op1 - op2;

    always_comb begin
        result = 32'd0;
        trap   = 1'b0;
        ovf    = 1'b0;
        case (d.operation)
            OP_ADD: begin
                result = sum;
                ovf    = (op1[31] == op2[31]) && (sum[31] != op1[31]);
            end
            OP_SUB: begin
                result = diff;
                ovf    = (op1[31] != op2[31]) && (diff[31] != op1[31]);
            end
            OP_ADDU: result = sum;
            OP_SUBU: result = diff;
            OP_SLT:  result = {31'd0, $signed(op1) < $signed(op2)};
            OP_SLTU: result = {31'd0, op1 < op2};
            OP_AND:  result = op1 & op2;
            OP_OR:   result = op1 | op2;
            OP_XOR:  result = op1 ^ op2;
            OP_NOR:  result = ~(op1 | op2);
            OP_SLL:  result = op2 << op1[4:0];
            OP_SRL:  result = op2 >> op1[4:0];
            OP_SRA:  result = $signed(op2) >>> op1[4:0];
            OP_LUI:  result = {d.imm, 16'd0};
            OP_MFHI, OP_MFLO, OP_MTHI, OP_MTLO, OP_MOVN, OP_MOVZ: result = op1;
            OP_TEQ:  trap = op1 == op2;
            OP_TNE:  trap = op1 != op2;
            default: result = 32'd0;
        endcase
    end

    // decode exceptions take priority, epc already holds the issuing pc
    always_comb begin
        exc = in_bus.exc;
        if (!in_bus.exc.ex && ovf) begin
            exc.ex      = 1'b1;
            exc.exccode = EXCCODE_OV;
        end else if (!in_bus.exc.ex && trap) begin
            exc.ex      = 1'b1;
            exc.exccode = EXCCODE_TR;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_bus.valid <= 1'b0;
        end else begin
            out_bus.valid <= in_bus.valid;
        end
    end

    always_ff @(posedge clk) begin
        out_bus.inst       <= d;
        out_bus.pc         <= in_bus.pc;
        out_bus.dest       <= in_bus.dest;
        out_bus.rf_we      <= in_bus.rf_we && !exc.ex;
        out_bus.result     <= result;
        out_bus.exc        <= exc;
        out_bus.write_hilo <= in_bus.write_hilo;
    end

endmodule

/* design/result_commit.sv */
`timescale 1ns/1ps

module result_commit (
    input  logic         clk,
    input  logic         rst_n,
    exec_bus_if.consumer in_bus,
    input  logic [5:0]   rd_idx1,
    input  logic [5:0]   rd_idx2,
    output logic [31:0]  rd_val1,
    output logic [31:0]  rd_val2,
    input  logic [5:0]   host_adr,
    output logic [31:0]  host_dat,
    output logic         commit_done
);
    import cpu_pkg::*;

    logic [31:0] gpr [1:31];
    logic [31:0] hi, lo;
    exception_t  status;

    // r0 and unused indices read as zero
    function automatic logic [31:0] read_reg(input logic [5:0] idx);
        logic [31:0] val;
        if (idx == REG_HI) begin
            val = hi;
        end else if (idx == REG_LO) begin
            val = lo;
        end else if (idx[5] || idx[4:0] == 5'd0) begin
            val = 32'd0;
        end else begin
            val = gpr[idx[4:0]];
        end
        return val;
    endfunction

    always_comb rd_val1 = read_reg(rd_idx1);
    always_comb rd_val2 = read_reg(rd_idx2);

    always_comb begin
        case (host_adr)
            ADR_STATUS: host_dat = {25'd0, status.exccode, 1'b0, status.ex};
            ADR_EPC:    host_dat = status.epc;
            default:    host_dat = read_reg(host_adr);
        endcase
    end

    assign commit_done = in_bus.valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                gpr[i] <= 32'd0;
            end
            hi     <= 32'd0;
            lo     <= 32'd0;
            status <= '0;
        end else if (in_bus.valid) begin
            // latest exception replaces the earlier one
            if (in_bus.exc.ex) begin
                status <= in_bus.exc;
            end else if (in_bus.rf_we) begin
                if (!in_bus.write_hilo) begin
                    gpr[in_bus.dest[4:0]] <= in_bus.result;
                end else if (in_bus.dest == REG_HI) begin
                    hi <= in_bus.result;
                end else begin
                    lo <= in_bus.result;
                end
            end
        end
    end

endmodule

/* design/mips_issue_top.sv */
`timescale 1ns/1ps

module mips_issue_top (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [5:0]  wb_adr,
    input  logic [31:0] wb_dat_i,
    output logic [31:0] wb_dat_o,
    output logic        wb_ack
);
    import cpu_pkg::*;

    logic        issue_valid;
    inst_u       inst;
    operation_t  operation;
    logic [31:0] pc;
    logic        commit_done;
    logic [5:0]  rd_idx1, rd_idx2;
    logic [31:0] rd_val1, rd_val2;

    exec_bus_if dec_bus ();
    exec_bus_if res_bus ();

    wb_issue_port wb_issue_port_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_dat_i    (wb_dat_i),
        .wb_ack      (wb_ack),
        .issue_valid (issue_valid),
        .inst        (inst),
        .pc          (pc),
        .commit_done (commit_done)
    );

    inst_decode inst_decode_i (
        .inst      (inst),
        .operation (operation)
    );

    control_signal control_signal_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .issue_valid (issue_valid),
        .pc          (pc),
        .inst        (inst),
        .operation   (operation),
        .bus         (dec_bus)
    );

    exec_alu exec_alu_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .in_bus  (dec_bus),
        .out_bus (res_bus),
        .rd_idx1 (rd_idx1),
        .rd_idx2 (rd_idx2),
        .rd_val1 (rd_val1),
        .rd_val2 (rd_val2)
    );

    result_commit result_commit_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_bus      (res_bus),
        .rd_idx1     (rd_idx1),
        .rd_idx2     (rd_idx2),
        .rd_val1     (rd_val1),
        .rd_val2     (rd_val2),
        .host_adr    (wb_adr),
        .host_dat    (wb_dat_o),
        .commit_done (commit_done)
    );

endmodule

/* verif/tb_mips_issue.sv */
`timescale 1ns/1ps

module tb_mips_issue;
    import cpu_pkg::*;

    // 40 cycles for each of the 126 bus accesses plus margin
    localparam int ACCESS_COUNT   = 126;
    localparam int TIMEOUT_CYCLES = ACCESS_COUNT * 40 + 100;

    logic        clk;
    logic        rst_n;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [5:0]  wb_adr;
    logic [31:0] wb_dat_i;
    logic [31:0] wb_dat_o;
    logic        wb_ack;

    // marks the cycle in which a new access is presented
    logic        access_start;
    logic        access_we;
    logic [31:0] exp_dat;
    string       test_name;

    logic [31:0] m_gpr [0:31];
    logic [31:0] m_hi, m_lo, m_epc;
    logic        m_ex;
    logic [4:0]  m_code;
    int          writes_issued;

    logic [31:0] rng_state;
    int          data_errors   = 0;
    int          timing_errors = 0;
    int          cycle_count   = 0;

    mips_issue_top mips_issue_top_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_i (wb_dat_i),
        .wb_dat_o (wb_dat_o),
        .wb_ack   (wb_ack)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    write_ack_latency: assert property (@(posedge clk) disable iff (!rst_n)
        access_start && access_we |-> ##1 !wb_ack ##1 !wb_ack ##1 !wb_ack ##1 wb_ack)
    else begin
        timing_errors++;
        $display("write was not acked exactly 4 cycles after it was accepted (%s)", test_name);
    end

    read_ack_latency: assert property (@(posedge clk) disable iff (!rst_n)
        access_start && !access_we |-> ##1 wb_ack)
    else begin
        timing_errors++;
        $display("read was not acked in the cycle after it was accepted (%s)", test_name);
    end

    ack_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        wb_ack |=> !wb_ack)
    else begin
        timing_errors++;
        $display("ack stayed high for more than one cycle");
    end

    read_data: assert property (@(posedge clk) disable iff (!rst_n)
        wb_ack && !wb_we |-> wb_dat_o == exp_dat)
    else begin
        data_errors++;
        $display("FAILED %s: expected %08h, actual %08h", test_name, exp_dat, wb_dat_o);
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("errors: %0d data, %0d timing", data_errors, timing_errors);
            $display("TEST FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic logic [31:0] encode_r(input logic [4:0] rs, input logic [4:0] rt,
                                             input logic [4:0] rd, input logic [4:0] sa,
                                             input logic [5:0] func);
        return {6'd0, rs, rt, rd, sa, func};
    endfunction

    function automatic logic [31:0] encode_i(input logic [5:0] op, input logic [4:0] rs,
                                             input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // registers 0..7 only so that r0 is a destination now and then
    function automatic logic [31:0] random_alu_inst(input logic [31:0] r1,
                                                    input logic [31:0] r2);
        logic [4:0] rs, rt, rd, sa;
        logic [5:0] func;
        int         sel;
        rs  = {2'd0, r1[2:0]};
        rt  = {2'd0, r1[5:3]};
        rd  = {2'd0, r1[8:6]};
        sa  = r1[13:9];
        sel = r2[31:16] % 24;
        if (sel >= 16) begin
            return encode_i(6'h08 + 6'(sel - 16), rs, rt, r2[15:0]);
        end
        case (sel)
            0: func = 6'h20;
            1: func = 6'h21;
            2: func = 6'h22;
            3: func = 6'h23;
            4: func = 6'h2a;
            5: func = 6'h2b;
            6: func = 6'h24;
            7: func = 6'h25;
            8: func = 6'h26;
            9: func = 6'h27;
            10: func = 6'h00;
            11: func = 6'h02;
            12: func = 6'h03;
            13: func = 6'h04;
            14: func = 6'h06;
            default: func = 6'h07;
        endcase
        return encode_r(rs, rt, rd, (sel >= 10 && sel <= 12) ? sa : 5'd0, func);
    endfunction

    function automatic bit fits_signed32(input longint v);
        return v == longint'(int'(v));
    endfunction

    task automatic set_gpr(input logic [4:0] idx, input logic [31:0] val);
        if (idx != 5'd0) begin
            m_gpr[idx] = val;
        end
    endtask

    // MIPS behavior of each supported instruction
    // an exception suppresses the write
    task automatic execute_reference(input logic [31:0] w);
        logic [5:0]  op, func;
        logic [4:0]  rs, rt, rd, sa, exc;
        logic [31:0] a, b, simm, zimm;
        longint      wide;
        op   = w[31:26];
        rs   = w[25:21];
        rt   = w[20:16];
        rd   = w[15:11];
        sa   = w[10:6];
        func = w[5:0];
        a    = m_gpr[rs];
        b    = m_gpr[rt];
        simm = {{16{w[15]}}, w[15:0]};
        zimm = {16'd0, w[15:0]};
        exc  = 5'd0;
        if (op == 6'h00) begin
            case (func)
                6'h20: begin
                    wide = longint'($signed(a)) + longint'($signed(b));
                    if (fits_signed32(wide)) set_gpr(rd, a + b);
                    else exc = EXCCODE_OV;
                end
                6'h22: begin
                    wide = longint'($signed(a)) - longint'($signed(b));
                    if (fits_signed32(wide)) set_gpr(rd, a - b);
                    else exc = EXCCODE_OV;
                end
                6'h21: set_gpr(rd, a + b);
                6'h23: set_gpr(rd, a - b);
                6'h24: set_gpr(rd, a & b);
                6'h25: set_gpr(rd, a | b);
                6'h26: set_gpr(rd, a ^ b);
                6'h27: set_gpr(rd, ~(a | b));
                6'h2a: set_gpr(rd, {31'd0, $signed(a) < $signed(b)});
                6'h2b: set_gpr(rd, {31'd0, a < b});
                6'h00: set_gpr(rd, b << sa);
                6'h02: set_gpr(rd, b >> sa);
                6'h03: set_gpr(rd, $signed(b) >>> sa);
                6'h04: set_gpr(rd, b << a[4:0]);
                6'h06: set_gpr(rd, b >> a[4:0]);
                6'h07: set_gpr(rd, $signed(b) >>> a[4:0]);
                6'h0a: if (b == 32'd0) set_gpr(rd, a);
                6'h0b: if (b != 32'd0) set_gpr(rd, a);
                6'h0c: exc = EXCCODE_SYS;
                6'h0d: exc = EXCCODE_BP;
                6'h10: set_gpr(rd, m_hi);
                6'h11: m_hi = a;
                6'h12: set_gpr(rd, m_lo);
                6'h13: m_lo = a;
                6'h34: if (a == b) exc = EXCCODE_TR;
                6'h36: if (a != b) exc = EXCCODE_TR;
                default: exc = EXCCODE_RI;
            endcase
        end else begin
            case (op)
                6'h01: begin
                    if (rt != 5'd12) exc = EXCCODE_RI;
                    else if (a == simm) exc = EXCCODE_TR;
                end
                6'h08: begin
                    wide = longint'($signed(a)) + longint'($signed(simm));
                    if (fits_signed32(wide)) set_gpr(rt, a + simm);
                    else exc = EXCCODE_OV;
                end
                6'h09: set_gpr(rt, a + simm);
                6'h0a: set_gpr(rt, {31'd0, $signed(a) < $signed(simm)});
                6'h0b: set_gpr(rt, {31'd0, a < simm});
                6'h0c: set_gpr(rt, a & zimm);
                6'h0d: set_gpr(rt, a | zimm);
                6'h0e: set_gpr(rt, a ^ zimm);
                6'h0f: set_gpr(rt, {w[15:0], 16'd0});
                default: exc = EXCCODE_RI;
            endcase
        end
        if (exc != 5'd0) begin
            m_ex   = 1'b1;
            m_code = exc;
            m_epc  = 32'(writes_issued * 4);
        end
        writes_issued++;
    endtask

    function automatic logic [31:0] reference_value(input logic [5:0] adr);
        if (adr < 6'd32) return m_gpr[adr[4:0]];
        if (adr == REG_HI) return m_hi;
        if (adr == REG_LO) return m_lo;
        if (adr == ADR_STATUS) return {25'd0, m_code, 1'b0, m_ex};
        if (adr == ADR_EPC) return m_epc;
        return 32'd0;
    endfunction

    // returns in the ack cycle
    // with hold set the strobe stays up for the next access
    task automatic bus_access(input logic we, input logic [5:0] adr,
                              input logic [31:0] dat, input bit hold);
        @(negedge clk);
        wb_cyc       = 1'b1;
        wb_stb       = 1'b1;
        wb_we        = we;
        wb_adr       = adr;
        wb_dat_i     = dat;
        access_start = 1'b1;
        access_we    = we;
        @(negedge clk);
        access_start = 1'b0;
        while (!wb_ack) @(negedge clk);
        if (!hold) begin
            @(negedge clk);
            wb_cyc = 1'b0;
            wb_stb = 1'b0;
            wb_we  = 1'b0;
        end
    endtask

    task automatic issue(input logic [31:0] w, input bit hold = 1'b0);
        execute_reference(w);
        bus_access(1'b1, 6'd0, w, hold);
    endtask

    task automatic check_reg(input string name, input logic [5:0] adr);
        test_name = name;
        exp_dat   = reference_value(adr);
        bus_access(1'b0, adr, 32'd0, 1'b0);
    endtask

    task automatic check_status(input string name);
        check_reg(name, ADR_STATUS);
        check_reg(name, ADR_EPC);
    endtask

    task automatic check_exception(input string name, input logic [5:0] dest);
        check_reg(name, dest);
        check_status(name);
    endtask

    initial begin
        logic [31:0] v, r1, r2, w;
        logic [5:0]  dest;
        rst_n         = 1'b0;
        wb_cyc        = 1'b0;
        wb_stb        = 1'b0;
        wb_we         = 1'b0;
        wb_adr        = 6'd0;
        wb_dat_i      = 32'd0;
        access_start  = 1'b0;
        access_we     = 1'b0;
        exp_dat       = 32'd0;
        test_name     = "reset";
        rng_state     = 32'd69;
        writes_issued = 0;
        m_hi          = 32'd0;
        m_lo          = 32'd0;
        m_epc         = 32'd0;
        m_ex          = 1'b0;
        m_code        = 5'd0;
        for (int i = 0; i < 32; i++) begin
            m_gpr[i] = 32'd0;
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // random setup of r1..r7 followed by random alu traffic
        for (int r = 1; r < 8; r++) begin
            v = lcg_next();
            issue(encode_i(6'h0f, 5'd0, r[4:0], v[31:16]));
            issue(encode_i(6'h0d, r[4:0], r[4:0], v[15:0]));
        end
        repeat (24) begin
            r1   = lcg_next();
            r2   = lcg_next();
            w    = random_alu_inst(r1, r2);
            dest = (w[31:26] == 6'd0) ? {1'b0, w[15:11]} : {1'b0, w[20:16]};
            issue(w);
            check_reg("alu_random", dest);
        end
        issue(encode_i(6'h09, 5'd1, 5'd0, 16'h0005));
        check_reg("r0_write", 6'd0);

        // hi/lo round trip and conditional moves
        issue(encode_i(6'h0d, 5'd0, 5'd8, 16'h1234));
        issue(encode_i(6'h0d, 5'd0, 5'd9, 16'h5678));
        issue(encode_r(5'd3, 5'd0, 5'd0, 5'd0, 6'h11));
        issue(encode_r(5'd4, 5'd0, 5'd0, 5'd0, 6'h13));
        check_reg("mthi", REG_HI);
        check_reg("mtlo", REG_LO);
        issue(encode_r(5'd0, 5'd0, 5'd5, 5'd0, 6'h10));
        issue(encode_r(5'd0, 5'd0, 5'd6, 5'd0, 6'h12));
        check_reg("mfhi", 6'd5);
        check_reg("mflo", 6'd6);
        issue(encode_r(5'd1, 5'd0, 5'd8, 5'd0, 6'h0b));
        check_reg("movn_keep", 6'd8);
        issue(encode_r(5'd1, 5'd0, 5'd9, 5'd0, 6'h0a));
        check_reg("movz_replace", 6'd9);
        issue(encode_r(5'd2, 5'd8, 5'd9, 5'd0, 6'h0b));
        check_reg("movn_replace", 6'd9);
        issue(encode_r(5'd2, 5'd8, 5'd8, 5'd0, 6'h0a));
        check_reg("movz_keep", 6'd8);

        // overflow and traps on r10 = 0x7fffffff, r11 = 1 and r13 = 0x80000000
        issue(encode_i(6'h0f, 5'd0, 5'd10, 16'h7fff));
        issue(encode_i(6'h0d, 5'd10, 5'd10, 16'hffff));
        issue(encode_i(6'h09, 5'd0, 5'd11, 16'h0001));
        issue(encode_i(6'h0f, 5'd0, 5'd13, 16'h8000));
        issue(encode_r(5'd10, 5'd11, 5'd12, 5'd0, 6'h20));
        check_exception("add_ovf", 6'd12);
        issue(encode_i(6'h08, 5'd10, 5'd12, 16'h0001));
        check_exception("addi_ovf", 6'd12);
        issue(encode_r(5'd13, 5'd11, 5'd12, 5'd0, 6'h22));
        check_exception("sub_ovf", 6'd12);
        issue(encode_r(5'd11, 5'd11, 5'd0, 5'd0, 6'h34));
        check_exception("teq_trap", 6'd12);
        issue(encode_r(5'd10, 5'd11, 5'd0, 5'd0, 6'h36));
        check_exception("tne_trap", 6'd12);
        issue(encode_i(6'h01, 5'd11, 5'd12, 16'h0001));
        check_exception("teqi_trap", 6'd12);

        issue(encode_r(5'd0, 5'd0, 5'd0, 5'd0, 6'h0c));
        check_status("syscall");
        issue(encode_r(5'd0, 5'd0, 5'd0, 5'd0, 6'h0d));
        check_status("break");
        issue(encode_i(6'h3f, 5'd1, 5'd2, 16'h0000));
        check_status("reserved_opcode");
        issue(encode_r(5'd1, 5'd2, 5'd3, 5'd0, 6'h01));
        check_status("reserved_func");

        // strobe stays up while the first write is in flight
        issue(encode_i(6'h0d, 5'd0, 5'd14, 16'h00ab), 1'b1);
        issue(encode_r(5'd14, 5'd14, 5'd15, 5'd0, 6'h21));
        check_reg("held_write", 6'd14);
        check_reg("held_write", 6'd15);

        repeat (2) @(negedge clk);
        $display("errors: %0d data, %0d timing", data_errors, timing_errors);
        if (data_errors == 0 && timing_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* sources.f */
design/cpu_pkg.sv
design/exec_bus_if.sv
design/wb_issue_port.sv
design/inst_decode.sv
design/control_signal.sv
design/exec_alu.sv
design/result_commit.sv
design/mips_issue_top.sv
verif/tb_mips_issue.sv
